// File: cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0.

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // lui passes the immediate through.
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } res_src_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// File: cpu_if.sv
interface de_bus;
    import cpu_pkg::*;

    logic     reg_write;
    res_src_e res_src;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
    logic     jump;
    alu_op_e  alu_op;
    logic     alu_src_imm;
    word_t    rd1;
    word_t    rd2;
    word_t    pc;
    word_t    pc_plus4;
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;

    modport src (output reg_write, res_src, mem_write, branch, branch_ne, jump, alu_op,
                 alu_src_imm, rd1, rd2, pc, pc_plus4, imm, rd, rs1, rs2);
    modport dst (input reg_write, res_src, mem_write, branch, branch_ne, jump, alu_op,
                 alu_src_imm, rd1, rd2, pc, pc_plus4, imm, rd, rs1, rs2);
endinterface

interface em_bus;
    import cpu_pkg::*;

    logic     reg_write;
    res_src_e res_src;
    logic     mem_write;
    word_t    alu_out; // also carries the link address for jal.
    word_t    write_data;
    reg_idx_t rd;

    modport src (output reg_write, res_src, mem_write, alu_out, write_data, rd);
    modport dst (input reg_write, res_src, mem_write, alu_out, write_data, rd);
    modport mon (input reg_write, res_src, rd);
endinterface

// File: fetch.sv
module fetch (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          flush,
    input  logic          pc_redirect,
    input  cpu_pkg::word_t pc_target,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t pc_d,
    output cpu_pkg::word_t pc_plus4_d,
    output cpu_pkg::word_t instr_d
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus4;

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) pc <= '0;
        else if (pc_redirect) pc <= pc_target; // taken branch or jal wins over stall.
        else if (!stall) pc <= pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            instr_d <= NOP_INSTR;
        end else if (!stall) begin
            instr_d    <= imem_data;
            pc_d       <= pc;
            pc_plus4_d <= pc_plus4;
        end
    end

endmodule

// File: decode.sv
module decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             flush,
    input  cpu_pkg::word_t    pc_d,
    input  cpu_pkg::word_t    pc_plus4_d,
    input  cpu_pkg::word_t    instr_d,
    input  logic             wb_reg_write,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_result,
    output cpu_pkg::reg_idx_t rs1_d,
    output cpu_pkg::reg_idx_t rs2_d,
    de_bus.src               de,
    output cpu_pkg::word_t    a0
);
    import cpu_pkg::*;

    word_t    regs [32];
    logic     reg_write_c, mem_write_c, branch_c, branch_ne_c, jump_c, alu_src_imm_c;
    logic     use_rs1, use_rs2;
    alu_op_e  alu_op_c;
    res_src_e res_src_c;
    word_t    imm_c;
    word_t    rd1_c, rd2_c;
    logic [2:0] funct3;

    assign funct3 = instr_d[14:12];

    always_comb begin
        reg_write_c   = 1'b0;
        mem_write_c   = 1'b0;
        branch_c      = 1'b0;
        branch_ne_c   = 1'b0;
        jump_c        = 1'b0;
        alu_src_imm_c = 1'b0;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        alu_op_c      = ALU_ADD;
        res_src_c     = RES_ALU;
        imm_c         = '0;
        case (instr_d[6:0])
            OP_R: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                reg_write_c = 1'b1;
                case (funct3)
                    3'b000:  alu_op_c = instr_d[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op_c = ALU_SLT;
                    3'b100:  alu_op_c = ALU_XOR;
                    3'b110:  alu_op_c = ALU_OR;
                    3'b111:  alu_op_c = ALU_AND;
                    default: reg_write_c = 1'b0; // unsupported, becomes a bubble.
                endcase
            end
            OP_I: begin
                reg_write_c   = (funct3 == 3'b000); // addi only.
                use_rs1       = 1'b1;
                alu_src_imm_c = 1'b1;
                imm_c         = {{20{instr_d[31]}}, instr_d[31:20]};
            end
            OP_LUI: begin
                reg_write_c   = 1'b1;
                alu_src_imm_c = 1'b1;
                alu_op_c      = ALU_PASS_B;
                imm_c         = {instr_d[31:12], 12'b0};
            end
            OP_LOAD: begin
                reg_write_c   = (funct3 == 3'b010); // lw only.
                res_src_c     = RES_MEM;
                use_rs1       = 1'b1;
                alu_src_imm_c = 1'b1;
                imm_c         = {{20{instr_d[31]}}, instr_d[31:20]};
            end
            OP_STORE: begin
                mem_write_c   = (funct3 == 3'b010); // sw only.
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                alu_src_imm_c = 1'b1;
                imm_c         = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            end
            OP_BRANCH: begin
                branch_c    = (funct3[2:1] == 2'b00); // beq and bne.
                branch_ne_c = funct3[0];
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                imm_c       = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                               instr_d[30:25], instr_d[11:8], 1'b0};
            end
            OP_JAL: begin
                reg_write_c = 1'b1;
                jump_c      = 1'b1;
                res_src_c   = RES_PC4;
                imm_c       = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                               instr_d[20], instr_d[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // unread source fields read as x0 so they never match a hazard.
    assign rs1_d = use_rs1 ? instr_d[19:15] : '0;
    assign rs2_d = use_rs2 ? instr_d[24:20] : '0;

    always_ff @(posedge clk) begin
        if (wb_reg_write && wb_rd != '0) regs[wb_rd] <= wb_result;
    end

    assign rd1_c = (rs1_d == '0) ? '0 :
                   (wb_reg_write && wb_rd == rs1_d) ? wb_result : regs[rs1_d]; // write-through.
    assign rd2_c = (rs2_d == '0) ? '0 :
                   (wb_reg_write && wb_rd == rs2_d) ? wb_result : regs[rs2_d];
    assign a0    = regs[10];

    always_ff @(posedge clk) begin
        if (!rst_n || stall || flush) begin
            de.reg_write <= 1'b0;
            de.res_src   <= RES_ALU;
            de.mem_write <= 1'b0;
            de.branch    <= 1'b0;
            de.branch_ne <= 1'b0;
            de.jump      <= 1'b0;
        end else begin
            de.reg_write <= reg_write_c;
            de.res_src   <= res_src_c;
            de.mem_write <= mem_write_c;
            de.branch    <= branch_c;
            de.branch_ne <= branch_ne_c;
            de.jump      <= jump_c;
        end
    end

    always_ff @(posedge clk) begin
        de.alu_op      <= alu_op_c;
        de.alu_src_imm <= alu_src_imm_c;
        de.rd1         <= rd1_c;
        de.rd2         <= rd2_c;
        de.pc          <= pc_d;
        de.pc_plus4    <= pc_plus4_d;
        de.imm         <= imm_c;
        de.rd          <= instr_d[11:7];
        de.rs1         <= rs1_d;
        de.rs2         <= rs2_d;
    end

endmodule

// File: execute.sv
module execute (
    input  logic             clk,
    input  logic             rst_n,
    de_bus.dst               de,
    input  cpu_pkg::fwd_sel_e fwd_a,
    input  cpu_pkg::fwd_sel_e fwd_b,
    input  cpu_pkg::word_t    wb_result,
    output logic             pc_redirect,
    output cpu_pkg::word_t    pc_target,
    em_bus.src               em
);
    import cpu_pkg::*;

    word_t src_a;
    word_t fwd_b_val;
    word_t src_b;
    word_t alu_y;
    word_t ex_result;
    logic  eq;

    always_comb begin
        case (fwd_a)
            FWD_MEM: src_a = em.alu_out;
            FWD_WB:  src_a = wb_result;
            default: src_a = de.rd1;
        endcase
    end

    always_comb begin
        case (fwd_b)
            FWD_MEM: fwd_b_val = em.alu_out;
            FWD_WB:  fwd_b_val = wb_result;
            default: fwd_b_val = de.rd2;
        endcase
    end

    assign src_b = de.alu_src_imm ? de.imm : fwd_b_val;

    always_comb begin
        case (de.alu_op)
            ALU_SUB:    alu_y = src_a - src_b;
            ALU_AND:    alu_y = src_a & src_b;
            ALU_OR:     alu_y = src_a | src_b;
            ALU_XOR:    alu_y = src_a ^ src_b;
            ALU_SLT:    alu_y = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_PASS_B: alu_y = src_b;
            default:    alu_y = src_a + src_b;
        endcase
    end

    // compare the register operands, not the immediate path.
    assign eq          = (src_a == fwd_b_val);
    assign pc_redirect = de.jump | (de.branch & (eq ^ de.branch_ne));
    assign pc_target   = de.pc + de.imm;
    assign ex_result   = (de.res_src == RES_PC4) ? de.pc_plus4 : alu_y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em.reg_write <= 1'b0;
            em.res_src   <= RES_ALU;
            em.mem_write <= 1'b0;
        end else begin
            em.reg_write <= de.reg_write;
            em.res_src   <= de.res_src;
            em.mem_write <= de.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        em.alu_out    <= ex_result;
        em.write_data <= fwd_b_val; // store data after forwarding.
        em.rd         <= de.rd;
    end

endmodule

// File: mem_wb.sv
module mem_wb #(
    parameter int DMEM_WORDS = 64
)(
    input  logic             clk,
    input  logic             rst_n,
    em_bus.dst               em,
    output logic             wb_reg_write,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_result
);
    import cpu_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t          dmem [DMEM_WORDS];
    logic [AW-1:0]  dmem_idx;
    word_t          read_data;
    res_src_e       res_src_w;
    word_t          alu_out_w;
    word_t          read_data_w;

    assign dmem_idx  = em.alu_out[AW+1:2]; // word addressed.
    assign read_data = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (em.mem_write) dmem[dmem_idx] <= em.write_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
            res_src_w    <= RES_ALU;
        end else begin
            wb_reg_write <= em.reg_write;
            res_src_w    <= em.res_src;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_w   <= em.alu_out;
        read_data_w <= read_data;
        wb_rd       <= em.rd;
    end

    // pc+4 of a jal already rides in alu_out.
    always_comb begin
        case (res_src_w)
            RES_MEM: wb_result = read_data_w;
            default: wb_result = alu_out_w;
        endcase
    end

endmodule

// File: hazard_unit.sv
module hazard_unit (
    input  cpu_pkg::reg_idx_t rs1_d,
    input  cpu_pkg::reg_idx_t rs2_d,
    de_bus.dst               de,
    em_bus.mon               em,
    input  logic             wb_reg_write,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic             pc_redirect,
    output logic             stall,
    output logic             flush,
    output cpu_pkg::fwd_sel_e fwd_a,
    output cpu_pkg::fwd_sel_e fwd_b
);
    import cpu_pkg::*;

    logic mem_fwd_ok;
    logic load_e;

    // a load in the memory stage has no result yet.
    assign mem_fwd_ok = em.reg_write && em.res_src != RES_MEM && em.rd != '0;

    always_comb begin
        if (mem_fwd_ok && em.rd == de.rs1) fwd_a = FWD_MEM;
        else if (wb_reg_write && wb_rd != '0 && wb_rd == de.rs1) fwd_a = FWD_WB;
        else fwd_a = FWD_RF;
    end

    always_comb begin
        if (mem_fwd_ok && em.rd == de.rs2) fwd_b = FWD_MEM;
        else if (wb_reg_write && wb_rd != '0 && wb_rd == de.rs2) fwd_b = FWD_WB;
        else fwd_b = FWD_RF;
    end

    assign load_e = de.reg_write && de.res_src == RES_MEM && de.rd != '0;
    assign stall  = load_e && (de.rd == rs1_d || de.rd == rs2_d);
    assign flush  = pc_redirect;

endmodule

// File: cpu.sv
module cpu #(
    parameter int DMEM_WORDS = 64
)(
    input  logic          clk,
    input  logic          rst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t a0
);
    import cpu_pkg::*;

    logic     stall;
    logic     flush;
    logic     pc_redirect;
    word_t    pc_target;
    word_t    pc_d;
    word_t    pc_plus4_d;
    word_t    instr_d;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    logic     wb_reg_write;
    reg_idx_t wb_rd;
    word_t    wb_result;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    de_bus de_if ();
    em_bus em_if ();

    fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .pc_redirect(pc_redirect), .pc_target(pc_target),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .pc_d(pc_d), .pc_plus4_d(pc_plus4_d), .instr_d(instr_d)
    );

    decode u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .pc_d(pc_d), .pc_plus4_d(pc_plus4_d), .instr_d(instr_d),
        .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_result(wb_result),
        .rs1_d(rs1_d), .rs2_d(rs2_d), .de(de_if.src), .a0(a0)
    );

    execute u_execute (
        .clk(clk), .rst_n(rst_n), .de(de_if.dst), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .wb_result(wb_result), .pc_redirect(pc_redirect), .pc_target(pc_target),
        .em(em_if.src)
    );

    mem_wb #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .em(em_if.dst),
        .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_result(wb_result)
    );

    hazard_unit hu (
        .rs1_d(rs1_d), .rs2_d(rs2_d), .de(de_if.dst), .em(em_if.mon),
        .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .pc_redirect(pc_redirect),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

// File: tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS  = 5;
localparam int PROG_WORDS = 16;

word_t prog_tab  [NUM_TESTS][PROG_WORDS];
int    prog_len  [NUM_TESTS];
int    halt_idx  [NUM_TESTS];
word_t exp_a0    [NUM_TESTS];
string test_name [NUM_TESTS];

task automatic emit(input int t, input word_t w);
    prog_tab[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

// the self-loop jal marks where a program stops.
task automatic halt_here(input int t);
    halt_idx[t] = prog_len[t];
    emit(t, jal(0, 0));
endtask

task automatic build_programs();
    logic [31:0] r;
    word_t       sum;
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t] = 0;
    end
    test_name[0] = "alu chain with forwarding";
    emit(0, addi(1, 0, 100));
    emit(0, addi(2, 1, -30));
    emit(0, rop(32, 0, 3, 1, 2));  // sub x3, x1, x2.
    emit(0, lui(4, 'h12345));
    emit(0, rop(0, 0, 5, 4, 3));   // add x5, x4, x3.
    emit(0, rop(0, 2, 6, 3, 2));   // slt x6, x3, x2.
    emit(0, rop(0, 4, 7, 5, 6));   // xor x7, x5, x6.
    emit(0, rop(0, 6, 8, 7, 1));   // or x8, x7, x1.
    emit(0, rop(0, 7, 9, 8, 2));   // and x9, x8, x2.
    emit(0, rop(0, 0, 10, 8, 9));  // add x10, x8, x9.
    halt_here(0);
    exp_a0[0] = 32'h1234_50c5;
    test_name[1] = "store, load and load-use";
    emit(1, addi(1, 0, 'h55));
    emit(1, addi(2, 0, 16));
    emit(1, sw(1, 2, 4));
    emit(1, lw(3, 2, 4));
    emit(1, rop(0, 0, 10, 3, 3));  // add x10, x3, x3 right after the load.
    emit(1, addi(4, 0, -7));
    emit(1, sw(4, 2, 0));
    emit(1, lw(5, 2, 0));
    emit(1, rop(32, 0, 10, 10, 5)); // sub x10, x10, x5.
    halt_here(1);
    exp_a0[1] = 32'd177;
    test_name[2] = "taken and not-taken branches";
    emit(2, addi(10, 0, 1));
    emit(2, addi(1, 0, 5));
    emit(2, addi(2, 0, 5));
    emit(2, beq(1, 2, 12));        // taken, skips the next two.
    emit(2, addi(10, 10, 100));
    emit(2, addi(10, 10, 200));
    emit(2, bne(1, 2, 8));         // not taken.
    emit(2, addi(10, 10, 2));
    emit(2, addi(2, 2, 1));
    emit(2, bne(1, 2, 12));        // taken.
    emit(2, addi(10, 10, 400));
    emit(2, addi(10, 10, 800));
    emit(2, beq(1, 2, 8));         // not taken.
    emit(2, addi(10, 10, 4));
    halt_here(2);
    exp_a0[2] = 32'd7;
    test_name[3] = "jal link and x0";
    emit(3, addi(10, 0, 0));
    emit(3, jal(1, 8));            // x1 = 8.
    emit(3, addi(10, 10, 50));
    emit(3, jal(0, 8));
    emit(3, addi(10, 10, 60));
    emit(3, rop(0, 0, 10, 1, 0));  // add x10, x1, x0.
    emit(3, addi(0, 0, 77));
    emit(3, rop(0, 0, 10, 10, 0)); // add x10, x10, x0.
    emit(3, jal(2, 8));            // x2 = 36.
    emit(3, addi(10, 10, 1000));
    emit(3, rop(0, 0, 10, 10, 2)); // add x10, x10, x2.
    halt_here(3);
    exp_a0[3] = 32'd44;
    test_name[4] = "random addi chain";
    sum = '0;
    for (int i = 0; i < 8; i++) begin
        r   = $random(seed);
        sum = sum + {{20{r[11]}}, r[11:0]};
        emit(4, addi(10, (i == 0) ? 0 : 10, int'(r)));
    end
    halt_here(4);
    exp_a0[4] = sum;
endtask

`endif

// File: tb_cpu.sv
module tb_cpu #(
    parameter logic [31:0] SEED = 32'h934b_f951
);
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    HALT_VISITS  = 8;
    localparam int    RUN_LIMIT    = 150; // cycles allowed per program.
    localparam word_t NOP_WORD     = 32'h0000_0013; // addi x0, x0, 0.

    logic   clk;
    logic   rst_n;
    word_t  imem_addr;
    word_t  imem_data;
    word_t  a0;
    word_t  imem [16];
    int     imem_len;
    int     word_idx;
    integer seed;
    int     errors;
    int     n_pass;
    int     n_fail;

    function automatic word_t itype(input int imm, input int rs1, input int f3, input int rd,
                                    input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return itype(imm, rs1, 0, rd, 7'b0010011);
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return itype(imm, rs1, 2, rd, 7'b0000011);
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t rop(input int f7, input int f3, input int rd, input int rs1,
                                  input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t branch(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t beq(input int rs1, input int rs2, input int off);
        return branch(0, rs1, rs2, off);
    endfunction

    function automatic word_t bne(input int rs1, input int rs2, input int off);
        return branch(1, rs1, rs2, off);
    endfunction

    function automatic word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    `include "tb_programs.svh"

    localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;

    cpu #(.DMEM_WORDS(64)) UUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data), .a0(a0)
    );

    // words past the end of the program read as nops.
    always_comb begin
        word_idx = int'(imem_addr >> 2);
        if (word_idx < imem_len) imem_data = imem[word_idx];
        else imem_data = NOP_WORD;
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_program(input int t);
        int    errs_before;
        int    visits;
        int    cycles;
        word_t halt_addr;
        errs_before = errors;
        halt_addr   = word_t'(halt_idx[t] * 4);
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        imem_len = prog_len[t];
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog_tab[t][i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(imem_addr, 32'h0, "fetch address after reset");
        visits = 0;
        cycles = 0;
        // the halt jal refetches its own address every third cycle.
        while (visits < HALT_VISITS && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (imem_addr == halt_addr) visits++;
            else if (imem_addr < halt_addr || imem_addr > halt_addr + 8) visits = 0;
        end
        if (visits < HALT_VISITS) begin
            errors++;
            $display("test %0d (%s): the program never settled at its halt address %h",
                     t, test_name[t], halt_addr);
        end else begin
            check(a0, exp_a0[t], "a0 at halt");
            $display("test %0d (%s): %s, a0 = %h", t, test_name[t],
                     (errors == errs_before) ? "pass" : "fail", a0);
        end
        if (errors == errs_before) n_pass++;
        else n_fail++;
    endtask

    initial begin
        rst_n    = 1'b0;
        imem_len = 0;
        seed     = SEED;
        errors   = 0;
        n_pass   = 0;
        n_fail   = 0;
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_program(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
cpu_pkg.sv
cpu_if.sv
fetch.sv
decode.sv
execute.sv
mem_wb.sv
hazard_unit.sv
cpu.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 32'h934bf951
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST) tb_programs.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) "-GSEED=$(SEED)" \
		--Mdir $(SIM_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR) $(LOG)
